//--- testbench/hci_queues_golden.txt
# op addr data: W write, R read and expect, P engine push, C engine pop and expect, S check flags
# S flags: 5 resp_wready, 4 resp_full, 3 resp_trig, 2 cmd_rvalid, 1 cmd_empty, 0 cmd_trig
R 0c 00040000
S 00 00000022
R 08 00000101
W 00 11111111
W 00 22222222
W 00 33333333
R 0c 00010003
C 00 11111111
C 00 22222222
C 00 33333333
S 00 00000022
P 00 aaaa0001
P 00 aaaa0002
R 04 aaaa0001
R 04 aaaa0002
R 04 00000000
W 08 00000302
R 08 00000302
W 00 44444444
P 00 bbbb0001
P 00 bbbb0002
S 00 00000024
W 00 55555555
P 00 bbbb0003
S 00 0000002d
R 0c 00030302
C 00 44444444
C 00 55555555
P 00 bbbb0004
S 00 0000001a
W 00 66666661
W 00 66666662
W 00 66666663
W 00 66666664
W 00 66666665
S 00 0000001d
C 00 66666661
C 00 66666662
C 00 66666663
C 00 66666664
C 00 66666665
W 00 77777777
W 10 00000006
R 10 00000000
R 0c 00040000
S 00 00000022

//--- src.f
source/hci_pkg.sv
source/hci_queue.sv
source/hci_queue_csr.sv
source/hci_queues_top.sv
testbench/tb_hci_queues.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the testbench with Verilator; a nonzero exit status means failure
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f src.f --top-module tb_hci_queues -o tb_hci_queues \
  && ./obj_dir/tb_hci_queues \
  || { echo "Simulation did not complete successfully"; exit 1; }

//--- testbench/tb_hci_queues.sv
// Run from the project root; golden file expects QueueDepth 4; first mismatch ends the run
`timescale 1ns/1ps
`default_nettype none

module tb_hci_queues;

  logic               clk_i;
  logic               arst_n_i;
  logic               wb_cyc_i;
  logic               wb_stb_i;
  logic               wb_we_i;
  hci_pkg::csr_addr_t wb_adr_i;
  hci_pkg::csr_data_t wb_dat_i;
  hci_pkg::csr_data_t wb_dat_o;
  logic               wb_ack_o;
  logic               hci_cmd_rvalid_o;
  logic               hci_cmd_rready_i;
  hci_pkg::csr_data_t hci_cmd_rdata_o;
  logic               hci_cmd_ready_thld_trig_o;
  logic               hci_cmd_empty_o;
  logic               hci_resp_wvalid_i;
  logic               hci_resp_wready_o;
  hci_pkg::csr_data_t hci_resp_wdata_i;
  logic               hci_resp_ready_thld_trig_o;
  logic               hci_resp_full_o;

  logic [7:0]         op_q[$];
  hci_pkg::csr_data_t a_q[$];
  hci_pkg::csr_data_t b_q[$];
  int                 n_ops = 0;
  logic               bus_busy = 1'b0;
  logic               bus_stalled = 1'b0;
  hci_pkg::csr_data_t bus_rdata;
  hci_pkg::csr_addr_t wr_adr;
  hci_pkg::csr_data_t wr_dat;

  hci_queues_top #(.QueueDepth(4)) dut_i (
    .clk_i                      (clk_i),
    .arst_n_i                   (arst_n_i),
    .wb_cyc_i                   (wb_cyc_i),
    .wb_stb_i                   (wb_stb_i),
    .wb_we_i                    (wb_we_i),
    .wb_adr_i                   (wb_adr_i),
    .wb_dat_i                   (wb_dat_i),
    .wb_dat_o                   (wb_dat_o),
    .wb_ack_o                   (wb_ack_o),
    .hci_cmd_rvalid_o           (hci_cmd_rvalid_o),
    .hci_cmd_rready_i           (hci_cmd_rready_i),
    .hci_cmd_rdata_o            (hci_cmd_rdata_o),
    .hci_cmd_ready_thld_trig_o  (hci_cmd_ready_thld_trig_o),
    .hci_cmd_empty_o            (hci_cmd_empty_o),
    .hci_resp_wvalid_i          (hci_resp_wvalid_i),
    .hci_resp_wready_o          (hci_resp_wready_o),
    .hci_resp_wdata_i           (hci_resp_wdata_i),
    .hci_resp_ready_thld_trig_o (hci_resp_ready_thld_trig_o),
    .hci_resp_full_o            (hci_resp_full_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_value(input string what, input hci_pkg::csr_data_t got,
                             input hci_pkg::csr_data_t exp);
    assert (got === exp) else begin
      $display("FAIL at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  // Flag layout matches the S lines of the golden file
  function automatic hci_pkg::csr_data_t output_flags();
    return {26'b0, hci_resp_wready_o, hci_resp_full_o, hci_resp_ready_thld_trig_o,
            hci_cmd_rvalid_o, hci_cmd_empty_o, hci_cmd_ready_thld_trig_o};
  endfunction

  task automatic load_golden();
    int         fd;
    int         code;
    int         ch;
    logic [7:0] letter;
    logic       malformed;
    hci_pkg::csr_data_t x;
    hci_pkg::csr_data_t y;
    malformed = 1'b0;
    fd = $fopen("testbench/hci_queues_golden.txt", "r");
    assert (fd != 0) else begin
      $display("The golden file testbench/hci_queues_golden.txt could not be opened");
      $display("RESULT: FAIL");
      $fatal(1, "No stimulus");
    end
    code = $fscanf(fd, " %c", letter);
    while (code == 1 && !malformed) begin
      if (letter == "#") begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else if ($fscanf(fd, "%h %h", x, y) == 2) begin
        op_q.push_back(letter);
        a_q.push_back(x);
        b_q.push_back(y);
      end else begin
        malformed = 1'b1;
      end
      code = $fscanf(fd, " %c", letter);
    end
    $fclose(fd);
    assert (!malformed && op_q.size() != 0) else begin
      $display("The golden file is malformed or holds no operations");
      $display("RESULT: FAIL");
      $fatal(1, "Bad stimulus");
    end
  endtask

  // A write may stay pending on back-pressure; engine ops and S checks may then proceed
  task automatic wait_for_turn(input logic need_bus);
    wait (!bus_busy || (!need_bus && bus_stalled));
  endtask

  task automatic bus_access(input logic we, input hci_pkg::csr_addr_t adr,
                            input hci_pkg::csr_data_t dat);
    int cycles;
    cycles = 0;
    bus_busy = 1'b1;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    do begin
      @(posedge clk_i);
      #1;
      cycles++;
      // Back-to-back requests lose one cycle to the previous ack
      if (cycles == 2 && !wb_ack_o) begin
        bus_stalled = 1'b1;
      end
    end while (!wb_ack_o);
    bus_rdata = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    bus_stalled = 1'b0;
    bus_busy = 1'b0;
  endtask

  task automatic engine_push(input hci_pkg::csr_data_t dat);
    hci_resp_wvalid_i = 1'b1;
    hci_resp_wdata_i  = dat;
    @(posedge clk_i);
    #1;
    hci_resp_wvalid_i = 1'b0;
  endtask

  task automatic engine_pop(input hci_pkg::csr_data_t exp);
    check_value("command rvalid", {31'b0, hci_cmd_rvalid_o}, 32'd1);
    check_value("command head", hci_cmd_rdata_o, exp);
    hci_cmd_rready_i = 1'b1;
    @(posedge clk_i);
    #1;
    hci_cmd_rready_i = 1'b0;
  endtask

  // Watchdog sized from the golden line count
  initial begin
    wait (n_ops != 0);
    #(n_ops * 100 * 20);
    $display("Watchdog expired before the golden file was finished");
    $display("RESULT: FAIL");
    $fatal(1, "Timeout");
  end

  initial begin
    logic [7:0]         op;
    hci_pkg::csr_data_t a;
    hci_pkg::csr_data_t b;
    arst_n_i          = 1'b0;
    wb_cyc_i          = 1'b0;
    wb_stb_i          = 1'b0;
    wb_we_i           = 1'b0;
    wb_adr_i          = '0;
    wb_dat_i          = '0;
    hci_cmd_rready_i  = 1'b0;
    hci_resp_wvalid_i = 1'b0;
    hci_resp_wdata_i  = '0;
    load_golden();
    n_ops = op_q.size();
    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    check_value("ack after reset", {31'b0, wb_ack_o}, 32'd0);
    for (int i = 0; i < n_ops; i++) begin
      op = op_q[i];
      a  = a_q[i];
      b  = b_q[i];
      case (op)
        "W": begin
          wait_for_turn(1'b1);
          wr_adr   = a[4:0];
          wr_dat   = b;
          bus_busy = 1'b1;
          fork
            bus_access(1'b1, wr_adr, wr_dat);
          join_none
        end
        "R": begin
          wait_for_turn(1'b1);
          bus_access(1'b0, a[4:0], '0);
          check_value($sformatf("read of %02h", a[4:0]), bus_rdata, b);
        end
        "P": begin
          wait_for_turn(1'b0);
          engine_push(b);
        end
        "C": begin
          wait_for_turn(1'b0);
          engine_pop(b);
        end
        "S": begin
          wait_for_turn(1'b0);
          check_value("status outputs", output_flags(), b);
        end
        default: begin
          $display("Unknown operation on golden line %0d", i);
          $display("RESULT: FAIL");
          $fatal(1, "Bad operation");
        end
      endcase
    end
    wait (!bus_busy);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/hci_queues_top.sv
// HCI command and response queues behind Wishbone classic; QueueDepth is a power of two, 2 to 128
`timescale 1ns/1ps
`default_nettype none

module hci_queues_top #(
  parameter int unsigned QueueDepth = hci_pkg::DefaultQueueDepth
) (
  input  logic               clk_i,
  input  logic               arst_n_i,

  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  hci_pkg::csr_addr_t wb_adr_i,
  input  hci_pkg::csr_data_t wb_dat_i,
  output hci_pkg::csr_data_t wb_dat_o,
  output logic               wb_ack_o,

  output logic               hci_cmd_rvalid_o,
  input  logic               hci_cmd_rready_i,
  output hci_pkg::csr_data_t hci_cmd_rdata_o,
  output logic               hci_cmd_ready_thld_trig_o,
  output logic               hci_cmd_empty_o,

  input  logic               hci_resp_wvalid_i,
  output logic               hci_resp_wready_o,
  input  hci_pkg::csr_data_t hci_resp_wdata_i,
  output logic               hci_resp_ready_thld_trig_o,
  output logic               hci_resp_full_o
);

  hci_pkg::queue_cfg_t    cmd_cfg;
  hci_pkg::queue_cfg_t    resp_cfg;
  hci_pkg::queue_status_t cmd_status;
  hci_pkg::queue_status_t resp_status;
  logic                   cmd_push;
  hci_pkg::csr_data_t     cmd_wdata;
  logic                   resp_pop;
  hci_pkg::csr_data_t     resp_rdata;

  hci_queue_csr u_csr (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .cmd_cfg_o     (cmd_cfg),
    .cmd_status_i  (cmd_status),
    .cmd_push_o    (cmd_push),
    .cmd_wdata_o   (cmd_wdata),
    .resp_cfg_o    (resp_cfg),
    .resp_status_i (resp_status),
    .resp_pop_o    (resp_pop),
    .resp_rdata_i  (resp_rdata)
  );

  // Engine pops only take effect while the queue is not empty
  hci_queue #(.QueueDepth(QueueDepth)) u_cmd_queue (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_i       (cmd_cfg),
    .push_i      (cmd_push),
    .push_data_i (cmd_wdata),
    .pop_i       (hci_cmd_rready_i),
    .head_data_o (hci_cmd_rdata_o),
    .status_o    (cmd_status)
  );

  // Engine pushes are dropped while full
  hci_queue #(.QueueDepth(QueueDepth)) u_resp_queue (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_i       (resp_cfg),
    .push_i      (hci_resp_wvalid_i),
    .push_data_i (hci_resp_wdata_i),
    .pop_i       (resp_pop),
    .head_data_o (resp_rdata),
    .status_o    (resp_status)
  );

  assign hci_cmd_rvalid_o           = ~cmd_status.empty;
  assign hci_cmd_empty_o            = cmd_status.empty;
  assign hci_cmd_ready_thld_trig_o  = cmd_status.thld_trig;
  assign hci_resp_wready_o          = ~resp_status.full;
  assign hci_resp_full_o            = resp_status.full;
  assign hci_resp_ready_thld_trig_o = resp_status.thld_trig;

endmodule

`default_nettype wire

//--- source/hci_queue_csr.sv
// Wishbone classic register block; one-cycle ack, command writes to a full queue stall until space
`timescale 1ns/1ps
`default_nettype none

module hci_queue_csr (
  input  logic                   clk_i,
  input  logic                   arst_n_i,

  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  hci_pkg::csr_addr_t     wb_adr_i,
  input  hci_pkg::csr_data_t     wb_dat_i,
  output hci_pkg::csr_data_t     wb_dat_o,
  output logic                   wb_ack_o,

  output hci_pkg::queue_cfg_t    cmd_cfg_o,
  input  hci_pkg::queue_status_t cmd_status_i,
  output logic                   cmd_push_o,
  output hci_pkg::csr_data_t     cmd_wdata_o,

  output hci_pkg::queue_cfg_t    resp_cfg_o,
  input  hci_pkg::queue_status_t resp_status_i,
  output logic                   resp_pop_o,
  input  hci_pkg::csr_data_t     resp_rdata_i
);

  logic               req;
  logic               stall;
  logic               accept;
  logic               wr_en;
  logic               rd_en;
  logic               ack_q;
  hci_pkg::thld_t     cmd_thld_q;
  hci_pkg::thld_t     resp_thld_q;
  logic               cmd_rst_q;
  logic               resp_rst_q;
  hci_pkg::csr_data_t rdata_d;
  hci_pkg::csr_data_t rdata_q;

  // No new request while the previous ack is out
  assign req = wb_cyc_i & wb_stb_i & ~ack_q;

  // Back-pressure on a full command queue
  assign stall  = req & wb_we_i & (wb_adr_i == hci_pkg::CmdPortAddr) & cmd_status_i.full;
  assign accept = req & ~stall;
  assign wr_en  = accept & wb_we_i;
  assign rd_en  = accept & ~wb_we_i;

  assign cmd_push_o  = wr_en & (wb_adr_i == hci_pkg::CmdPortAddr);
  assign cmd_wdata_o = wb_dat_i;
  assign resp_pop_o  = rd_en & (wb_adr_i == hci_pkg::RespPortAddr) & ~resp_status_i.empty;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q       <= 1'b0;
      cmd_thld_q  <= hci_pkg::thld_t'(1);
      resp_thld_q <= hci_pkg::thld_t'(1);
      cmd_rst_q   <= 1'b0;
      resp_rst_q  <= 1'b0;
    end else begin
      ack_q <= accept;
      if (wr_en && (wb_adr_i == hci_pkg::ThldCtrlAddr)) begin
        cmd_thld_q  <= wb_dat_i[7:0];
        resp_thld_q <= wb_dat_i[15:8];
      end
      // One-cycle pulses that clear the queues on the following edge
      cmd_rst_q  <= wr_en & (wb_adr_i == hci_pkg::ResetCtrlAddr)
                    & wb_dat_i[hci_pkg::CmdRstBit];
      resp_rst_q <= wr_en & (wb_adr_i == hci_pkg::ResetCtrlAddr)
                    & wb_dat_i[hci_pkg::RespRstBit];
    end
  end

  // Unmapped and write-only locations read as zero
  always_comb begin
    rdata_d = '0;
    case (wb_adr_i)
      hci_pkg::RespPortAddr: begin
        if (!resp_status_i.empty) begin
          rdata_d = resp_rdata_i;
        end
      end
      hci_pkg::ThldCtrlAddr: begin
        rdata_d[7:0]  = cmd_thld_q;
        rdata_d[15:8] = resp_thld_q;
      end
      hci_pkg::QueueStatusAddr: begin
        rdata_d[7:0]  = cmd_status_i.depth;
        rdata_d[15:8] = resp_status_i.depth;
        rdata_d[16]   = cmd_status_i.thld_trig;
        rdata_d[17]   = resp_status_i.thld_trig;
        rdata_d[18]   = cmd_status_i.empty;
        rdata_d[19]   = resp_status_i.full;
      end
      default: rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign wb_ack_o = ack_q;
  assign wb_dat_o = rdata_q;

  always_comb begin
    cmd_cfg_o.thld      = cmd_thld_q;
    cmd_cfg_o.soft_rst  = cmd_rst_q;
    resp_cfg_o.thld     = resp_thld_q;
    resp_cfg_o.soft_rst = resp_rst_q;
  end

endmodule

`default_nettype wire

//--- source/hci_queue.sv
// FWFT queue; QueueDepth a power of two, 2 to 128; full pushes and empty pops are ignored
`timescale 1ns/1ps
`default_nettype none

module hci_queue #(
  parameter int unsigned QueueDepth = hci_pkg::DefaultQueueDepth
) (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  hci_pkg::queue_cfg_t    cfg_i,
  input  logic                   push_i,
  input  hci_pkg::csr_data_t     push_data_i,
  input  logic                   pop_i,
  output hci_pkg::csr_data_t     head_data_o,
  output hci_pkg::queue_status_t status_o
);

  localparam int unsigned PtrWidth = $clog2(QueueDepth);

  hci_pkg::csr_data_t  mem_q [QueueDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  hci_pkg::depth_t     depth_q;
  hci_pkg::thld_t      thld_eff;
  logic                empty;
  logic                full;
  logic                do_push;
  logic                do_pop;

  assign empty   = (depth_q == '0);
  assign full    = (depth_q == hci_pkg::depth_t'(QueueDepth));
  assign do_push = push_i & ~full;
  assign do_pop  = pop_i & ~empty;

  // Zero threshold behaves as one
  assign thld_eff = (cfg_i.thld == '0) ? hci_pkg::thld_t'(1) : cfg_i.thld;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      depth_q  <= '0;
    end else if (cfg_i.soft_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      depth_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop keeps the depth
      case ({do_push, do_pop})
        2'b10:   depth_q <= depth_q + 1'b1;
        2'b01:   depth_q <= depth_q - 1'b1;
        default: depth_q <= depth_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Head is valid only while not empty
  assign head_data_o = mem_q[rd_ptr_q];

  always_comb begin
    status_o.depth     = depth_q;
    status_o.empty     = empty;
    status_o.full      = full;
    status_o.thld_trig = (depth_q >= thld_eff);
  end

endmodule

`default_nettype wire

//--- source/hci_pkg.sv
// Shared HCI queue types and register map; 32-bit single-word commands, 5-bit byte addresses
`default_nettype none

package hci_pkg;

  typedef logic [31:0] csr_data_t;
  typedef logic [4:0]  csr_addr_t;
  typedef logic [7:0]  thld_t;
  typedef logic [7:0]  depth_t;

  // Register window
  localparam csr_addr_t CmdPortAddr     = 5'h00;
  localparam csr_addr_t RespPortAddr    = 5'h04;
  localparam csr_addr_t ThldCtrlAddr    = 5'h08;
  localparam csr_addr_t QueueStatusAddr = 5'h0C;
  localparam csr_addr_t ResetCtrlAddr   = 5'h10;

  // Soft reset bits in ResetCtrlAddr
  localparam int unsigned CmdRstBit  = 1;
  localparam int unsigned RespRstBit = 2;

  localparam int unsigned DefaultQueueDepth = 16;

  typedef struct packed {
    thld_t thld;
    logic  soft_rst;
  } queue_cfg_t;

  typedef struct packed {
    depth_t depth;
    logic   empty;
    logic   full;
    logic   thld_trig;
  } queue_status_t;

endpackage

`default_nettype wire
